/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	localparam int XLEN       = 32;
	localparam int REG_COUNT  = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;
	localparam int IMM16_W    = 16;
	localparam int TARGET_W   = 26;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // JAL return address

	// Primary opcodes
	localparam logic [OPCODE_W-1:0] OPC_RTYPE  = 6'b000000;
	localparam logic [OPCODE_W-1:0] OPC_REGIMM = 6'b000001;
	localparam logic [OPCODE_W-1:0] OPC_J      = 6'b000010;
	localparam logic [OPCODE_W-1:0] OPC_JAL    = 6'b000011;
	localparam logic [OPCODE_W-1:0] OPC_BEQ    = 6'b000100;
	localparam logic [OPCODE_W-1:0] OPC_BNE    = 6'b000101;
	localparam logic [OPCODE_W-1:0] OPC_BLEZ   = 6'b000110;
	localparam logic [OPCODE_W-1:0] OPC_BGTZ   = 6'b000111;
	localparam logic [OPCODE_W-1:0] OPC_ADDI   = 6'b001000;
	localparam logic [OPCODE_W-1:0] OPC_ADDIU  = 6'b001001;
	localparam logic [OPCODE_W-1:0] OPC_SLTI   = 6'b001010;
	localparam logic [OPCODE_W-1:0] OPC_SLTIU  = 6'b001011;
	localparam logic [OPCODE_W-1:0] OPC_ORI    = 6'b001101;
	localparam logic [OPCODE_W-1:0] OPC_XORI   = 6'b001110;
	localparam logic [OPCODE_W-1:0] OPC_LUI    = 6'b001111;
	localparam logic [OPCODE_W-1:0] OPC_LB     = 6'b100000;
	localparam logic [OPCODE_W-1:0] OPC_LW     = 6'b100011;
	localparam logic [OPCODE_W-1:0] OPC_LBU    = 6'b100100;
	localparam logic [OPCODE_W-1:0] OPC_SB     = 6'b101000;
	localparam logic [OPCODE_W-1:0] OPC_SW     = 6'b101011;

	// R-type function codes
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
	localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;
	localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
	localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
	localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
	localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
	localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
	localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
	localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
	localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
	localparam logic [FUNCT_W-1:0] FN_JALR = 6'b001001;

	// REGIMM selectors in the rt field
	localparam logic [REG_ADDR_W-1:0] RI_BLTZ = 5'b00000;
	localparam logic [REG_ADDR_W-1:0] RI_BGEZ = 5'b00001;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_REGIMM,
		FMT_J,
		FMT_BAD
	} insn_fmt_e;

	typedef enum logic [5:0] {
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
		OP_AND, OP_OR, OP_XOR, OP_NOR, OP_JR, OP_JALR,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI, OP_LUI,
		OP_LW, OP_LB, OP_LBU, OP_SW, OP_SB,
		OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
		OP_BLTZ, OP_BGEZ,
		OP_J, OP_JAL,
		OP_ILLEGAL
	} decode_op_e;

endpackage

`default_nettype wire

/* design/insn_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_classifier (
	input  wire logic [mips_pkg::XLEN-1:0] insn,
	output mips_pkg::insn_fmt_e            fmt,
	output mips_pkg::decode_op_e           op
);

	logic [mips_pkg::OPCODE_W-1:0]   opcode;
	logic [mips_pkg::FUNCT_W-1:0]    funct;
	logic [mips_pkg::REG_ADDR_W-1:0] ri_sel;

	assign opcode = insn[mips_pkg::XLEN-1 -: mips_pkg::OPCODE_W];
	assign funct  = insn[mips_pkg::FUNCT_W-1:0];
	assign ri_sel = insn[20:16]; // rt field selects the REGIMM branch

	always_comb begin
		fmt = mips_pkg::FMT_BAD;
		op  = mips_pkg::OP_ILLEGAL;
		case (opcode)
			mips_pkg::OPC_RTYPE: begin
				fmt = mips_pkg::FMT_R;
				case (funct)
					mips_pkg::FN_ADD:  op = mips_pkg::OP_ADD;
					mips_pkg::FN_ADDU: op = mips_pkg::OP_ADDU;
					mips_pkg::FN_SUB:  op = mips_pkg::OP_SUB;
					mips_pkg::FN_SUBU: op = mips_pkg::OP_SUBU;
					mips_pkg::FN_SLT:  op = mips_pkg::OP_SLT;
					mips_pkg::FN_SLTU: op = mips_pkg::OP_SLTU;
					mips_pkg::FN_SLL:  op = mips_pkg::OP_SLL; // Also the NOP word
					mips_pkg::FN_SLLV: op = mips_pkg::OP_SLLV;
					mips_pkg::FN_SRL:  op = mips_pkg::OP_SRL;
					mips_pkg::FN_SRLV: op = mips_pkg::OP_SRLV;
					mips_pkg::FN_SRA:  op = mips_pkg::OP_SRA;
					mips_pkg::FN_SRAV: op = mips_pkg::OP_SRAV;
					mips_pkg::FN_AND:  op = mips_pkg::OP_AND;
					mips_pkg::FN_OR:   op = mips_pkg::OP_OR;
					mips_pkg::FN_XOR:  op = mips_pkg::OP_XOR;
					mips_pkg::FN_NOR:  op = mips_pkg::OP_NOR;
					mips_pkg::FN_JR:   op = mips_pkg::OP_JR;
					mips_pkg::FN_JALR: op = mips_pkg::OP_JALR;
					default:           fmt = mips_pkg::FMT_BAD; // Mult/div group lands here
				endcase
			end
			mips_pkg::OPC_REGIMM: begin
				fmt = mips_pkg::FMT_REGIMM;
				case (ri_sel)
					mips_pkg::RI_BLTZ: op = mips_pkg::OP_BLTZ;
					mips_pkg::RI_BGEZ: op = mips_pkg::OP_BGEZ;
					default:           fmt = mips_pkg::FMT_BAD;
				endcase
			end
			mips_pkg::OPC_J: begin
				fmt = mips_pkg::FMT_J;
				op  = mips_pkg::OP_J;
			end
			mips_pkg::OPC_JAL: begin
				fmt = mips_pkg::FMT_J;
				op  = mips_pkg::OP_JAL;
			end
			mips_pkg::OPC_ADDI: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_ADDI;
			end
			mips_pkg::OPC_ADDIU: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_ADDIU;
			end
			mips_pkg::OPC_SLTI: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_SLTI;
			end
			mips_pkg::OPC_SLTIU: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_SLTIU;
			end
			mips_pkg::OPC_ORI: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_ORI;
			end
			mips_pkg::OPC_XORI: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_XORI;
			end
			mips_pkg::OPC_LUI: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_LUI;
			end
			mips_pkg::OPC_LW: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_LW;
			end
			mips_pkg::OPC_LB: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_LB;
			end
			mips_pkg::OPC_LBU: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_LBU;
			end
			mips_pkg::OPC_SW: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_SW;
			end
			mips_pkg::OPC_SB: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_SB;
			end
			mips_pkg::OPC_BEQ: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_BEQ;
			end
			mips_pkg::OPC_BNE: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_BNE;
			end
			mips_pkg::OPC_BGTZ: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_BGTZ;
			end
			mips_pkg::OPC_BLEZ: begin
				fmt = mips_pkg::FMT_I;
				op  = mips_pkg::OP_BLEZ;
			end
			default: ;
		endcase
	end

	// A known word must give a known op, and OP_ILLEGAL only together with FMT_BAD
	always_comb begin
		if (!$isunknown(insn)) begin
			a_op_known: assert final (!$isunknown(op) &&
				((op == mips_pkg::OP_ILLEGAL) == (fmt == mips_pkg::FMT_BAD)))
				else $error("insn_classifier: bad op/fmt for word %h", insn);
		end
	end

endmodule

`default_nettype wire

/* design/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select (
	input  wire logic [mips_pkg::XLEN-1:0]       insn,
	input  wire mips_pkg::insn_fmt_e             fmt,
	input  wire mips_pkg::decode_op_e            op,
	output logic [mips_pkg::REG_ADDR_W-1:0]      rs_idx,
	output logic [mips_pkg::REG_ADDR_W-1:0]      rt_idx,
	output logic [mips_pkg::REG_ADDR_W-1:0]      dest,
	output logic                                 reg_write,
	output logic [mips_pkg::SHAMT_W-1:0]         shamt,
	output logic [mips_pkg::XLEN-1:0]            imm
);

	logic [mips_pkg::REG_ADDR_W-1:0] rs_f;
	logic [mips_pkg::REG_ADDR_W-1:0] rt_f;
	logic [mips_pkg::REG_ADDR_W-1:0] rd_f;
	logic [mips_pkg::SHAMT_W-1:0]    shamt_f;
	logic [mips_pkg::IMM16_W-1:0]    imm16;
	logic [mips_pkg::TARGET_W-1:0]   target;
	logic                            shift_by_field;

	assign rs_f    = insn[25:21];
	assign rt_f    = insn[20:16];
	assign rd_f    = insn[15:11];
	assign shamt_f = insn[10:6];
	assign imm16   = insn[mips_pkg::IMM16_W-1:0];
	assign target  = insn[mips_pkg::TARGET_W-1:0];

	assign shift_by_field = (op == mips_pkg::OP_SLL) || (op == mips_pkg::OP_SRL) ||
		(op == mips_pkg::OP_SRA);

	// Zero the read index where the field is not a source register
	assign rs_idx = (shift_by_field || op == mips_pkg::OP_LUI) ? '0 : rs_f;
	assign rt_idx = (op == mips_pkg::OP_JR || fmt == mips_pkg::FMT_J) ? '0 : rt_f;

	assign shamt = shift_by_field ? shamt_f : '0;

	always_comb begin
		dest      = '0;
		reg_write = 1'b0;
		if (fmt == mips_pkg::FMT_R) begin
			if (op != mips_pkg::OP_JR) begin // JALR still links through rd
				dest      = rd_f;
				reg_write = 1'b1;
			end
		end else begin
			case (op)
				mips_pkg::OP_ADDI,
				mips_pkg::OP_ADDIU,
				mips_pkg::OP_SLTI,
				mips_pkg::OP_SLTIU,
				mips_pkg::OP_ORI,
				mips_pkg::OP_XORI,
				mips_pkg::OP_LUI,
				mips_pkg::OP_LW,
				mips_pkg::OP_LB,
				mips_pkg::OP_LBU: begin
					dest      = rt_f;
					reg_write = 1'b1;
				end
				mips_pkg::OP_JAL: begin
					dest      = mips_pkg::LINK_REG;
					reg_write = 1'b1;
				end
				default: ; // Stores, branches, J, illegal
			endcase
		end
	end

	always_comb begin
		case (fmt)
			mips_pkg::FMT_I,
			mips_pkg::FMT_REGIMM: begin
				if (op == mips_pkg::OP_ORI || op == mips_pkg::OP_XORI) begin
					imm = {{(mips_pkg::XLEN - mips_pkg::IMM16_W){1'b0}}, imm16};
				end else begin
					imm = {{(mips_pkg::XLEN - mips_pkg::IMM16_W){imm16[mips_pkg::IMM16_W-1]}},
						imm16};
				end
			end
			mips_pkg::FMT_J: imm = {{(mips_pkg::XLEN - mips_pkg::TARGET_W){1'b0}}, target};
			default:         imm = '0; // R-type and illegal
		endcase
	end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire logic                             clock,
	input  wire logic                             rst_n,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0]  rs_idx,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0]  rt_idx,
	output logic [mips_pkg::XLEN-1:0]             rs_val,
	output logic [mips_pkg::XLEN-1:0]             rt_val,
	input  wire logic                             wb_en,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0]  wb_addr,
	input  wire logic [mips_pkg::XLEN-1:0]        wb_data
);

	logic [mips_pkg::XLEN-1:0] regs [mips_pkg::REG_COUNT];

	always_ff @(posedge clock) begin
		if (wb_en && wb_addr != '0) begin // r0 is hardwired
			regs[wb_addr] <= wb_data;
		end
	end

	// No bypass so a same-edge write shows up next cycle
	assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
	assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];

	a_r0_reads_zero: assert property (@(posedge clock) disable iff (!rst_n)
		((rs_idx == '0) |-> (rs_val == '0)) and ((rt_idx == '0) |-> (rt_val == '0)))
		else $error("reg_file: register 0 read back nonzero");

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire logic                             clock,
	input  wire logic                             rst_n,
	input  wire logic                             decode_valid,
	input  wire logic [mips_pkg::XLEN-1:0]        insn,
	input  wire logic [mips_pkg::XLEN-1:0]        pc,
	input  wire logic                             wb_en,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0]  wb_addr,
	input  wire logic [mips_pkg::XLEN-1:0]        wb_data,
	output logic                                  out_valid,
	output mips_pkg::decode_op_e                  op_out,
	output logic                                  illegal,
	output logic [mips_pkg::REG_ADDR_W-1:0]       rs_out,
	output logic [mips_pkg::REG_ADDR_W-1:0]       rt_out,
	output logic [mips_pkg::REG_ADDR_W-1:0]       dest_out,
	output logic                                  reg_write_out,
	output logic [mips_pkg::SHAMT_W-1:0]          shamt_out,
	output logic [mips_pkg::XLEN-1:0]             imm_out,
	output logic [mips_pkg::XLEN-1:0]             rs_val_out,
	output logic [mips_pkg::XLEN-1:0]             rt_val_out,
	output logic [mips_pkg::XLEN-1:0]             pc_out,
	output logic [mips_pkg::XLEN-1:0]             insn_out
);

	mips_pkg::insn_fmt_e             fmt;
	mips_pkg::decode_op_e            op;
	logic [mips_pkg::REG_ADDR_W-1:0] rs_idx;
	logic [mips_pkg::REG_ADDR_W-1:0] rt_idx;
	logic [mips_pkg::REG_ADDR_W-1:0] dest;
	logic                            reg_write;
	logic [mips_pkg::SHAMT_W-1:0]    shamt;
	logic [mips_pkg::XLEN-1:0]       imm;
	logic [mips_pkg::XLEN-1:0]       rs_val;
	logic [mips_pkg::XLEN-1:0]       rt_val;

	insn_classifier i_classifier (
		.insn (insn),
		.fmt  (fmt),
		.op   (op)
	);

	operand_select i_operand_select (
		.insn      (insn),
		.fmt       (fmt),
		.op        (op),
		.rs_idx    (rs_idx),
		.rt_idx    (rt_idx),
		.dest      (dest),
		.reg_write (reg_write),
		.shamt     (shamt),
		.imm       (imm)
	);

	reg_file i_reg_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.rs_val  (rs_val),
		.rt_val  (rt_val),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			out_valid <= decode_valid; // One pulse per strobe
			illegal   <= decode_valid && (fmt == mips_pkg::FMT_BAD);
		end
	end

	// Payload holds when no strobe
	always_ff @(posedge clock) begin
		if (decode_valid) begin
			op_out        <= op;
			rs_out        <= rs_idx;
			rt_out        <= rt_idx;
			dest_out      <= dest;
			reg_write_out <= reg_write;
			shamt_out     <= shamt;
			imm_out       <= imm;
			rs_val_out    <= rs_val;
			rt_val_out    <= rt_val;
			pc_out        <= pc;
			insn_out      <= insn;
		end
	end

	// An illegal word must leave as a marked result that writes nothing
	a_illegal_with_valid: assert property (@(posedge clock) disable iff (!rst_n)
		illegal |-> (out_valid && !reg_write_out && op_out == mips_pkg::OP_ILLEGAL))
		else $error("decode_stage: illegal flag without a clean illegal result");

endmodule

`default_nettype wire

/* bench/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns are name, word, op, illegal, rs, rt, dest, reg_write, shamt, imm
// The PC of entry i is entry_pc(i)
task automatic load_vectors();
	add_vector("add", enc_r(1, 2, 3, 0, 'h20), mips_pkg::OP_ADD, 0, 1, 2, 3, 1, 0, 0);
	add_vector("sub", enc_r(4, 5, 6, 0, 'h22), mips_pkg::OP_SUB, 0, 4, 5, 6, 1, 0, 0);
	add_vector("slt", enc_r(7, 8, 9, 0, 'h2a), mips_pkg::OP_SLT, 0, 7, 8, 9, 1, 0, 0);
	add_vector("and", enc_r(10, 11, 12, 0, 'h24), mips_pkg::OP_AND, 0, 10, 11, 12, 1, 0, 0);
	add_vector("nor", enc_r(13, 14, 15, 0, 'h27), mips_pkg::OP_NOR, 0, 13, 14, 15, 1, 0, 0);
	add_vector("srav", enc_r(16, 17, 18, 0, 'h07), mips_pkg::OP_SRAV, 0, 16, 17, 18, 1, 0, 0);
	add_vector("sll", enc_r(19, 20, 21, 7, 'h00), mips_pkg::OP_SLL, 0, 0, 20, 21, 1, 7, 0);
	add_vector("nop", 32'h0000_0000, mips_pkg::OP_SLL, 0, 0, 0, 0, 1, 0, 0); // rd is r0
	add_vector("addi_neg", enc_i('h08, 1, 2, 'hfff0), mips_pkg::OP_ADDI,
		0, 1, 2, 2, 1, 0, 32'hffff_fff0);
	add_vector("ori_zext", enc_i('h0d, 3, 4, 'h8001), mips_pkg::OP_ORI,
		0, 3, 4, 4, 1, 0, 32'h0000_8001);
	add_vector("lw", enc_i('h23, 5, 6, 'h0010), mips_pkg::OP_LW, 0, 5, 6, 6, 1, 0, 32'h10);
	add_vector("sw", enc_i('h2b, 7, 8, 'hfffc), mips_pkg::OP_SW,
		0, 7, 8, 0, 0, 0, 32'hffff_fffc);
	add_vector("beq", enc_i('h04, 9, 10, 'h0003), mips_pkg::OP_BEQ, 0, 9, 10, 0, 0, 0, 3);
	add_vector("bltz", enc_i('h01, 11, 0, 'h8000), mips_pkg::OP_BLTZ,
		0, 11, 0, 0, 0, 0, 32'hffff_8000);
	// Top target bits land in the rs field
	add_vector("j", enc_j('h02, 'h2abcdef), mips_pkg::OP_J, 0, 21, 0, 0, 0, 0, 32'h02ab_cdef);
	add_vector("jal", enc_j('h03, 'h0000400), mips_pkg::OP_JAL, 0, 0, 0, 31, 1, 0, 32'h400);
	add_vector("jr", enc_r(31, 5, 0, 0, 'h08), mips_pkg::OP_JR, 0, 31, 0, 0, 0, 0, 0);
	add_vector("mult", enc_r(1, 2, 0, 0, 'h18), mips_pkg::OP_ILLEGAL, 1, 1, 2, 0, 0, 0, 0);
	add_vector("div", enc_r(3, 4, 0, 0, 'h1a), mips_pkg::OP_ILLEGAL, 1, 3, 4, 0, 0, 0, 0);
	add_vector("bad_opcode", enc_i('h3f, 5, 6, 'h1234), mips_pkg::OP_ILLEGAL,
		1, 5, 6, 0, 0, 0, 0);
endtask

`endif

/* bench/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

	localparam int WAIT_LIMIT = 20; // Cycles to wait for out_valid

	typedef struct packed {
		logic [31:0]          insn;
		mips_pkg::decode_op_e op;
		logic                 illegal;
		logic [4:0]           rs;
		logic [4:0]           rt;
		logic [4:0]           dest;
		logic                 reg_write;
		logic [4:0]           shamt;
		logic [31:0]          imm;
	} vec_t;

	logic                 clock;
	logic                 rst_n;
	logic                 decode_valid;
	logic [31:0]          insn;
	logic [31:0]          pc;
	logic                 wb_en;
	logic [4:0]           wb_addr;
	logic [31:0]          wb_data;
	logic                 out_valid;
	mips_pkg::decode_op_e op_out;
	logic                 illegal;
	logic [4:0]           rs_out;
	logic [4:0]           rt_out;
	logic [4:0]           dest_out;
	logic                 reg_write_out;
	logic [4:0]           shamt_out;
	logic [31:0]          imm_out;
	logic [31:0]          rs_val_out;
	logic [31:0]          rt_val_out;
	logic [31:0]          pc_out;
	logic [31:0]          insn_out;

	logic [31:0] shadow [32]; // Expected register contents
	vec_t        vectors [$];
	string       names [$];
	int          errors;
	int          checks;
	bit          timed_out;

	decode_stage i_decode_stage (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
			input int sh, input int fn);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
	endfunction

	function automatic logic [31:0] enc_i(input int opc, input int rs, input int rt,
			input int imm);
		return {opc[5:0], rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_j(input int opc, input int target);
		return {opc[5:0], target[25:0]};
	endfunction

	function automatic logic [31:0] entry_pc(input int i);
		return 32'h0040_0000 + 4 * i;
	endfunction

	task automatic add_vector(input string name, input logic [31:0] word,
			input mips_pkg::decode_op_e op, input int ill, input int rs, input int rt,
			input int dest, input int wr, input int shamt, input logic [31:0] imm);
		vec_t v;
		v.insn      = word;
		v.op        = op;
		v.illegal   = (ill != 0);
		v.rs        = rs[4:0];
		v.rt        = rt[4:0];
		v.dest      = dest[4:0];
		v.reg_write = (wr != 0);
		v.shamt     = shamt[4:0];
		v.imm       = imm;
		names.push_back(name);
		vectors.push_back(v);
	endtask

	`include "decode_vectors.svh"

	task automatic check_value(input string name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_for_valid(input string name);
		int waited;
		waited = 0;
		while (!out_valid && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!out_valid) begin
			$display("Timeout: no out_valid for %s within %0d cycles", name, WAIT_LIMIT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic write_reg(input int idx, input logic [31:0] data);
		@(negedge clock);
		wb_en   = 1'b1;
		wb_addr = idx[4:0];
		wb_data = data;
		if (idx != 0) begin
			shadow[idx] = data;
		end
		@(negedge clock);
		wb_en = 1'b0;
	endtask

	// Drives one strobe and returns on the falling edge where the result should be out
	task automatic apply_strobe(input logic [31:0] word, input logic [31:0] addr);
		@(negedge clock);
		decode_valid = 1'b1;
		insn         = word;
		pc           = addr;
		@(negedge clock);
		decode_valid = 1'b0;
	endtask

	task automatic check_entry(input int i);
		vec_t  v;
		string n;
		v = vectors[i];
		n = names[i];
		check_value(n, "op", v.op, op_out);
		check_value(n, "illegal", v.illegal, illegal);
		check_value(n, "rs", v.rs, rs_out);
		check_value(n, "rt", v.rt, rt_out);
		check_value(n, "dest", v.dest, dest_out);
		check_value(n, "reg_write", v.reg_write, reg_write_out);
		check_value(n, "shamt", v.shamt, shamt_out);
		check_value(n, "imm", v.imm, imm_out);
		check_value(n, "rs_val", shadow[v.rs], rs_val_out);
		check_value(n, "rt_val", shadow[v.rt], rt_val_out);
		check_value(n, "pc", entry_pc(i), pc_out);
		check_value(n, "insn", v.insn, insn_out);
	endtask

	task automatic check_writeback();
		write_reg(5, 32'h1357_9bdf);
		write_reg(0, 32'hdead_beef); // Must be dropped
		apply_strobe(enc_r(5, 0, 7, 0, 'h20), 32'h0040_1000);
		wait_for_valid("wb_read");
		if (!timed_out) begin
			check_value("wb_read", "rs_val", 32'h1357_9bdf, rs_val_out);
			check_value("wb_read", "rt_val", 32'h0, rt_val_out);
		end
	endtask

	task automatic check_stream();
		logic [31:0] words [3];
		logic [31:0] addrs [3];
		for (int k = 0; k < 3; k++) begin
			words[k] = enc_i('h09, k + 1, k + 2, 'h0100 + k);
			addrs[k] = 32'h0040_2000 + 4 * k;
		end
		for (int k = 0; k <= 3; k++) begin
			@(negedge clock);
			if (k > 0) begin
				check_value("stream", "out_valid", 1, out_valid);
				check_value("stream", "pc_out", addrs[k-1], pc_out);
				check_value("stream", "insn_out", words[k-1], insn_out);
			end
			if (k < 3) begin
				decode_valid = 1'b1;
				insn         = words[k];
				pc           = addrs[k];
			end else begin
				decode_valid = 1'b0;
				insn         = '1; // Not to be captured
				pc           = '1;
			end
		end
		@(negedge clock);
		check_value("stream_gap", "out_valid", 0, out_valid);
		check_value("stream_gap", "pc_out", addrs[2], pc_out); // Payload holds
		check_value("stream_gap", "insn_out", words[2], insn_out);
	endtask

	initial begin
		void'($urandom(32'hfd8b));
		errors       = 0;
		checks       = 0;
		timed_out    = 1'b0;
		rst_n        = 1'b0;
		decode_valid = 1'b1; // Strobe an illegal word through reset
		insn         = 32'hfc00_0000;
		pc           = '0;
		wb_en        = 1'b0;
		wb_addr      = '0;
		wb_data      = '0;
		shadow[0]    = '0;
		load_vectors();
		repeat (5) @(negedge clock);
		rst_n        = 1'b1;
		decode_valid = 1'b0;
		check_value("after_reset", "out_valid", 0, out_valid);
		check_value("after_reset", "illegal", 0, illegal);
		for (int r = 1; r < 32; r++) begin
			write_reg(r, $urandom);
		end
		foreach (vectors[i]) begin
			if (!timed_out) begin
				apply_strobe(vectors[i].insn, entry_pc(i));
				wait_for_valid(names[i]);
				if (!timed_out) begin
					check_entry(i);
				end
			end
		end
		if (!timed_out) begin
			check_writeback();
		end
		if (!timed_out) begin
			check_stream();
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+bench
design/mips_pkg.sv
design/insn_classifier.sv
design/operand_select.sv
design/reg_file.sv
design/decode_stage.sv
bench/decode_stage_tb.sv
